// File: files.f
testCtlPkg.sv
sharedMem.sv
memArbiter.sv
hostAccessUnit.sv
printScanner.sv
pcMonitor.sv
testCtlTop.sv
tbClockGen.sv
tbChecker.sv
testCtl_assert.sv
tb_testCtl.sv

// File: hostAccessUnit.sv
// host port for sized reads and writes of 8, 16, 32 and 64 bits
// one command outstanding; response comes 2 cycles after the strobe

`timescale 1ns/1ps

module hostAccessUnit import testCtlPkg::*; (
   input  logic       dvtFlags,
   input  logic       pcFail,
   // host command
   input  logic       cmdStrobe,
   input  logic       cmdWrite,
   input  accessSizeT cmdSize,
   input  byteAddrT   cmdAddr,
   input  dataT       cmdData,
   output logic       rspValid,
   output dataT       rspData,
   // memory master
   output logic       req,
   output logic       writeEn,
   output wordAddrT   wordAddr,
   output maskT       mask,
   output dataT       wrData,
   input  logic       grant,
   input  logic       rdValid,
   input  dataT       rdData
);

   logic       busyQ;
   logic       writeQ;
   accessSizeT sizeQ;
   byteAddrT   addrQ;
   dataT       dataQ;
   dataT       laneData;   // addressed lane, zero-extended

   // --------------------------------------------------
   // command register
   // --------------------------------------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         busyQ <= 1'b0;
      end else if (cmdStrobe) begin
         busyQ <= 1'b1;
      end else if (grant) begin
         busyQ <= 1'b0;
      end
   end

   always_ff @(posedge dvtFlags) begin
      if (cmdStrobe) begin
         writeQ <= cmdWrite;
         sizeQ  <= cmdSize;
         addrQ  <= cmdAddr;
         dataQ  <= cmdData;
      end
   end

   assign req      = busyQ;
   assign writeEn  = writeQ;
   assign wordAddr = addrQ[10:3];

   // --------------------------------------------------
   // lane masks, replication and extraction
   // --------------------------------------------------
   always_comb begin
      case (sizeQ)
         sizeByte: begin
            mask     = maskT'(1) << addrQ[2:0];
            wrData   = {8{dataQ[7:0]}};
            laneData = dataT'(rdData[{addrQ[2:0], 3'b000} +: 8]);
         end
         sizeHalf: begin
            mask     = maskT'(2'b11) << {addrQ[2:1], 1'b0};
            wrData   = {4{dataQ[15:0]}};
            laneData = dataT'(rdData[{addrQ[2:1], 4'b0000} +: 16]);
         end
         sizeWord: begin
            mask     = addrQ[2] ? wordMaskHi : wordMaskLo;
            wrData   = {2{dataQ[31:0]}};
            laneData = dataT'(addrQ[2] ? rdData[63:32] : rdData[31:0]);
         end
         default: begin   // double
            mask     = fullMask;
            wrData   = dataQ;
            laneData = rdData;
         end
      endcase
   end

   // writes answer on the same schedule, with zero data
   assign rspValid = rdValid;
   assign rspData  = writeQ ? '0 : laneData;

endmodule

// File: memArbiter.sv
// fixed-priority arbiter putting the host or the print scanner on the memory
// host always wins; read data is returned with a valid to last cycle's winner

`timescale 1ns/1ps

module memArbiter import testCtlPkg::*; (
   input  logic     dvtFlags,
   input  logic     pcFail,
   // host master
   input  logic     hostReq,
   input  logic     hostWriteEn,
   input  wordAddrT hostAddr,
   input  maskT     hostMask,
   input  dataT     hostWrData,
   output logic     hostGrant,
   // scanner master, read only
   input  logic     scanReq,
   input  wordAddrT scanAddr,
   output logic     scanGrant,
   // memory side
   output logic     memWriteEn,
   output wordAddrT memAddr,
   output maskT     memMask,
   output dataT     memWrData,
   input  dataT     memRdData,
   // read return
   output dataT     rdData,
   output logic     hostRdValid,
   output logic     scanRdValid
);

   logic hostLastQ;  // host owned the memory last cycle
   logic scanLastQ;

   assign hostGrant = hostReq;
   assign scanGrant = scanReq & ~hostReq;   // only in host-idle cycles

   assign memWriteEn = hostReq & hostWriteEn;
   assign memAddr    = hostReq ? hostAddr : scanAddr;
   assign memMask    = hostMask;    // ignored unless writing
   assign memWrData  = hostWrData;

   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         hostLastQ <= 1'b0;
         scanLastQ <= 1'b0;
      end else begin
         hostLastQ <= hostGrant;
         scanLastQ <= scanGrant;
      end
   end

   assign rdData      = memRdData;
   assign hostRdValid = hostLastQ;
   assign scanRdValid = scanLastQ;

endmodule

// File: pcMonitor.sv
// watches the core PC trace for the pass and fail addresses and a stuck PC
// first decision latches both status bits

`timescale 1ns/1ps

module pcMonitor import testCtlPkg::*; (
   input  logic dvtFlags,
   input  logic pcFail,
   input  logic pcValid,
   input  pcT   curPc,
   input  pcT   passPc,
   input  pcT   failPc,
   output logic testPassed,
   output logic testFailed
);

   pcT        lastPc;
   repeatCntT repeatCnt;   // saturates at stuckLimit

   logic samePc;
   logic stuck;
   logic passHit;
   logic failHit;

   assign samePc  = (curPc == lastPc);
   // this repeat brings the count to the limit
   assign stuck   = pcValid && samePc && (repeatCnt >= repeatCntT'(stuckLimit - 1));
   assign passHit = pcValid && (curPc[pcCmpBits-1:0] == passPc[pcCmpBits-1:0]);
   assign failHit = (pcValid && (curPc[pcCmpBits-1:0] == failPc[pcCmpBits-1:0])) || stuck;

   // --------------------------------------------------
   // repeat tracking
   // --------------------------------------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         lastPc    <= '0;
         repeatCnt <= '0;
      end else if (pcValid) begin
         lastPc <= curPc;
         if (!samePc) begin
            repeatCnt <= '0;
         end else if (repeatCnt != repeatCntT'(stuckLimit)) begin
            repeatCnt <= repeatCnt + 1'b1;
         end
      end
   end

   // --------------------------------------------------
   // sticky status
   // --------------------------------------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         testPassed <= 1'b0;
         testFailed <= 1'b0;
      end else if (!testPassed && !testFailed) begin
         if (failHit) begin
            testFailed <= 1'b1;   // fail wins a tie
         end else if (passHit) begin
            testPassed <= 1'b1;
         end
      end
   end

endmodule

// File: printScanner.sv
// reads one 128-byte line from shared memory and streams its characters
// stops at NUL, LF or CR, or after the whole line; printDone marks the end

`timescale 1ns/1ps

module printScanner import testCtlPkg::*; (
   input  logic     dvtFlags,
   input  logic     pcFail,
   // print request
   input  logic     printStrobe,
   input  byteAddrT printAddr,
   output logic     charValid,
   output charT     charData,
   output logic     printDone,
   output logic     printBusy,
   // memory master, read only
   output logic     req,
   output wordAddrT wordAddr,
   input  logic     grant,
   input  logic     rdValid,
   input  dataT     rdData
);

   scanStateT  state;
   logic [3:0] lineQ;       // line index, address bits 10:7
   logic [3:0] issueCnt;    // words requested so far
   logic [1:0] inFlight;
   logic [1:0] qCount;
   logic       wrPtr;
   logic       rdPtr;
   dataT       wordQueue [2];
   dataT       curWord;     // word being drained, lane 0 at the bottom
   logic       curValid;
   logic [2:0] byteIdx;
   logic [6:0] charCnt;
   logic       fullDoneQ;

   logic start;
   logic isTerm;
   logic termHit;
   logic emit;
   logic lastChar;
   logic finish;
   logic issue;
   logic push;
   logic pop;

   assign start    = (state == scanIdle) && printStrobe;
   assign isTerm   = (curWord[7:0] == charNul) || (curWord[7:0] == charLf)
                     || (curWord[7:0] == charCr);
   assign termHit  = curValid && isTerm;
   assign emit     = curValid && !isTerm;
   assign lastChar = emit && (charCnt == 7'(lineBytes - 1));
   assign finish   = termHit || lastChar;
   assign issue    = req && grant;
   assign push     = rdValid && (state != scanIdle);   // late data dropped in idle
   assign pop      = (qCount != 2'd0) && !finish
                     && (!curValid || (emit && byteIdx == 3'd7));

   // queued plus outstanding never exceeds the two queue entries
   assign req      = (state == scanRead) && (({1'b0, qCount} + {1'b0, inFlight}) < 3'd2);
   assign wordAddr = {lineQ, issueCnt};

   // --------------------------------------------------
   // control
   // --------------------------------------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         state     <= scanIdle;
         issueCnt  <= '0;
         inFlight  <= '0;
         qCount    <= '0;
         wrPtr     <= 1'b0;
         rdPtr     <= 1'b0;
         curValid  <= 1'b0;
         byteIdx   <= '0;
         charCnt   <= '0;
         fullDoneQ <= 1'b0;
      end else begin
         fullDoneQ <= lastChar;
         if (start) begin
            state    <= scanRead;
            issueCnt <= '0;
            inFlight <= '0;
            qCount   <= '0;
            wrPtr    <= 1'b0;
            rdPtr    <= 1'b0;
            charCnt  <= '0;
         end else if (finish) begin
            state    <= scanIdle;
            curValid <= 1'b0;
            qCount   <= '0;    // anything still queued is thrown away
         end else begin
            if (issue && issueCnt == 4'(lineWords - 1)) state <= scanDrain;
            if (issue) issueCnt <= issueCnt + 4'd1;
            inFlight <= inFlight + 2'(issue) - 2'(push);
            qCount   <= qCount + 2'(push) - 2'(pop);
            if (push) wrPtr <= ~wrPtr;
            if (pop) rdPtr <= ~rdPtr;
            if (pop) begin
               curValid <= 1'b1;
               byteIdx  <= '0;
            end else if (emit) begin
               byteIdx <= byteIdx + 3'd1;
               if (byteIdx == 3'd7) curValid <= 1'b0;
            end
            if (emit) charCnt <= charCnt + 7'd1;
         end
      end
   end

   // --------------------------------------------------
   // data path
   // --------------------------------------------------
   always_ff @(posedge dvtFlags) begin
      if (start) lineQ <= printAddr[10:7];
      if (push) wordQueue[wrPtr] <= rdData;
      if (pop) begin
         curWord <= wordQueue[rdPtr];
      end else if (emit) begin
         curWord <= curWord >> laneBits;   // next lane down
      end
   end

   assign charValid = emit;
   assign charData  = curWord[7:0];
   assign printBusy = (state != scanIdle);
   assign printDone = termHit || fullDoneQ;

endmodule

// File: run.sh
#!/bin/bash
# compile and run the test-control testbench with Verilator
set -e
set -o pipefail

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_testCtl
./obj_dir/Vtb_testCtl 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

// File: sharedMem.sv
// word memory shared by the host port and the print scanner
// byte-lane writes, read data registered one cycle after the access

`timescale 1ns/1ps

module sharedMem import testCtlPkg::*; (
   input  logic     dvtFlags,
   input  logic     pcFail,
   input  logic     writeEn,
   input  wordAddrT wordAddr,
   input  maskT     mask,
   input  dataT     wrData,
   output dataT     rdData
);

   dataT memArray [memWords];

   // only the enabled lanes change
   always_ff @(posedge dvtFlags) begin
      if (writeEn) begin
         for (int lane = 0; lane < byteLanes; lane++) begin
            if (mask[lane]) begin
               memArray[wordAddr][lane*laneBits +: laneBits] <= wrData[lane*laneBits +: laneBits];
            end
         end
      end
   end

   // old contents on a same-cycle write
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         rdData <= '0;
      end else begin
         rdData <= memArray[wordAddr];
      end
   end

endmodule

// File: tbChecker.sv
// checker for the test-control testbench
// samples DUT outputs on the falling edge, compares them with the model and counts errors

`timescale 1ns/1ps

module tbChecker import testCtlPkg::*; (
   input  logic dvtFlags,
   input  logic pcFail,
   // host port
   input  logic cmdStrobe,
   input  logic rspValid,
   input  dataT rspData,
   input  dataT expRsp,
   // print port
   input  logic printStrobe,
   input  logic charValid,
   input  charT charData,
   input  logic printDone,
   input  logic printBusy,
   input  charT expLine [lineBytes],
   input  int   expLen,
   // status
   input  logic testPassed,
   input  logic testFailed,
   input  logic expPassed,
   input  logic expFailed,
   // counts
   output int   errCount,
   output int   rspCount,
   output int   charCount,
   output int   doneCount
);

   logic rspPending;
   int   rspAge;    // cycles since the strobe
   int   charIdx;   // next expected character
   logic charPrev;  // a character came out last cycle
   logic startSeen; // print accepted last cycle
   logic doneSeen;  // printDone last cycle

   initial begin
      errCount   = 0;
      rspCount   = 0;
      charCount  = 0;
      doneCount  = 0;
      rspPending = 1'b0;
      rspAge     = 0;
      charIdx    = 0;
      charPrev   = 1'b0;
      startSeen  = 1'b0;
      doneSeen   = 1'b0;
   end

   always @(negedge dvtFlags) begin
      if (pcFail) begin
         rspPending = 1'b0;
         charIdx    = 0;
         charPrev   = 1'b0;
         startSeen  = 1'b0;
         doneSeen   = 1'b0;
      end else begin
         // --------------------------------------------------
         // host responses
         // --------------------------------------------------
         if (rspPending) rspAge = rspAge + 1;
         if (rspValid) begin
            rspCount++;
            if (!rspPending) begin
               $display("response pulse at %0t without a pending command", $time);
               errCount++;
            end else if (rspAge != 2) begin
               $display("** Error at %0t: rspValid latency expected 2, got %0d", $time, rspAge);
               errCount++;
            end
            if (rspData !== expRsp) begin
               $display("** Error at %0t: rspData expected %h, got %h", $time, expRsp, rspData);
               errCount++;
            end
            rspPending = 1'b0;
         end else if (rspPending && rspAge >= 2) begin
            $display("no response pulse 2 cycles after the command, seen at %0t", $time);
            errCount++;
            rspPending = 1'b0;
         end
         if (cmdStrobe) begin
            rspPending = 1'b1;
            rspAge     = 0;
         end

         // --------------------------------------------------
         // print stream
         // --------------------------------------------------
         if (startSeen && printBusy !== 1'b1) begin
            $display("** Error at %0t: printBusy expected 1, got %b", $time, printBusy);
            errCount++;
         end
         if (doneSeen && printBusy !== 1'b0) begin
            $display("** Error at %0t: printBusy expected 0, got %b", $time, printBusy);
            errCount++;
         end
         if (charValid) begin
            charCount++;
            if (charIdx >= expLen) begin
               $display("** Error at %0t: charValid expected 0, got 1", $time);
               errCount++;
            end else if (charData !== expLine[charIdx]) begin
               $display("** Error at %0t: charData expected %h, got %h", $time,
                        expLine[charIdx], charData);
               errCount++;
            end
            charIdx++;
         end
         if (printDone) begin
            doneCount++;
            if (charIdx != expLen) begin
               $display("printDone at %0t after %0d characters, %0d were expected", $time,
                        charIdx, expLen);
               errCount++;
            end
            if (charIdx > 0 && !charPrev) begin
               $display("printDone at %0t did not come right after the last character", $time);
               errCount++;
            end
            charIdx = 0;
         end
         charPrev  = charValid;
         startSeen = printStrobe && !printBusy;
         doneSeen  = printDone;

         // status levels, model follows the deciding cycle
         if (testPassed !== expPassed) begin
            $display("** Error at %0t: testPassed expected %b, got %b", $time, expPassed,
                     testPassed);
            errCount++;
         end
         if (testFailed !== expFailed) begin
            $display("** Error at %0t: testFailed expected %b, got %b", $time, expFailed,
                     testFailed);
            errCount++;
         end
      end
   end

endmodule

// File: tbClockGen.sv
// clock and reset source for the test-control testbench
// 4 ns clock; reset is held for 5 cycles at start and again on each resetReq

`timescale 1ns/1ps

module tbClockGen (
   input  logic resetReq,
   output logic dvtFlags,
   output logic pcFail
);

   initial begin
      dvtFlags = 1'b0;
      forever #2 dvtFlags = ~dvtFlags;
   end

   initial begin
      pcFail = 1'b1;
      forever begin
         repeat (5) @(posedge dvtFlags);
         #1 pcFail = 1'b0;   // release between edges
         @(posedge resetReq);
         pcFail = 1'b1;
      end
   end

endmodule

// File: tb_testCtl.sv
// testbench top for the test-control block
// seeded random host traffic, print lines and PC traces against a byte-level model

`timescale 1ns/1ps

module tb_testCtl import testCtlPkg::*; ();

   localparam int numPairs    = 40;
   localparam int numBusyCmds = 30;
   localparam int numPcSteps  = 20;
   localparam int cmdCycles   = 3;   // strobe to next strobe
   localparam int testCycles  = memWords * cmdCycles + (2 * numPairs + 8) * cmdCycles
                                + 3 * (lineWords * cmdCycles + 2 * lineBytes)
                                + numBusyCmds * cmdCycles + 3 * (numPcSteps + 20) + stuckLimit;
   localparam int timeoutCycles = 2 * testCycles + 200;

   logic       dvtFlags, pcFail, resetReq;
   logic       cmdStrobe, cmdWrite, rspValid;
   accessSizeT cmdSize;
   byteAddrT   cmdAddr, printAddr;
   dataT       cmdData, rspData;
   logic       printStrobe, charValid, printDone, printBusy;
   charT       charData;
   logic       pcValid, testPassed, testFailed;
   pcT         curPc, passPc, failPc;

   // model state
   logic [7:0] refMem [memWords * byteLanes];
   dataT       expRsp;
   charT       expLine [lineBytes];
   int         expLen;
   logic       expPassed, expFailed;
   pcT         lastPcM;
   int         repeatM;
   int         errCount, rspCount, charCount, doneCount;
   int         cycleCnt = 0;
   integer     seed;

   tbClockGen u_clk (.resetReq, .dvtFlags, .pcFail);
   testCtlTop u_dut (.*);
   tbChecker  u_chk (.*);

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------
   function automatic logic [7:0] fillByte(input int addr);
      return 8'(addr) ^ 8'(addr >> 5) ^ 8'h5A;
   endfunction

   function automatic dataT rand64();
      return {$random(seed), $random(seed)};
   endfunction

   function automatic pcT randomPc();
      pcT pc;
      pc = rand64();
      if (pc[pcCmpBits-1:0] == passPc[pcCmpBits-1:0] ||
          pc[pcCmpBits-1:0] == failPc[pcCmpBits-1:0]) pc[0] = ~pc[0];
      return pc;
   endfunction

   // same low bits as target, upper bits differ
   function automatic pcT hitPc(input pcT target);
      pcT pc;
      pc = target;
      pc[63:pcCmpBits] = ~target[63:pcCmpBits];
      return pc;
   endfunction

   task automatic nextCycle();
      @(posedge dvtFlags);
      #1;
   endtask

   task automatic hostCmd(input logic wr, input accessSizeT sz, input byteAddrT addr,
                          input dataT data);
      int   nBytes;
      int   base;
      dataT exp;
      nBytes = 1 << int'(sz);
      base   = int'(addr) & ~(nBytes - 1);   // low address bits are ignored
      exp    = '0;
      for (int i = 0; i < nBytes; i++) begin
         if (wr) refMem[base + i] = data[i*8 +: 8];
         else exp[i*8 +: 8] = refMem[base + i];
      end
      expRsp    = exp;
      cmdWrite  = wr;
      cmdSize   = sz;
      cmdAddr   = addr;
      cmdData   = data;
      cmdStrobe = 1'b1;
      nextCycle();
      cmdStrobe = 1'b0;
      while (!rspValid) @(negedge dvtFlags);
      nextCycle();
   endtask

   task automatic randomCmd(input logic wr, input byteAddrT addr);
      hostCmd(wr, accessSizeT'(2'($random(seed))), addr, rand64());
   endtask

   // termPos of lineBytes means no terminator
   task automatic loadLine(input int line, input int termPos);
      dataT word;
      charT ch;
      int   pick;
      for (int b = 0; b < lineBytes; b++) begin
         ch = 8'h20 + 8'($unsigned($random(seed)) % 95);   // printable only
         if (b == termPos) begin
            pick = $unsigned($random(seed)) % 3;
            ch   = (pick == 0) ? charNul : (pick == 1) ? charLf : charCr;
         end
         expLine[b] = ch;
         word[(b % 8)*8 +: 8] = ch;
         if (b % 8 == 7) hostCmd(1'b1, sizeDouble, byteAddrT'(line * lineBytes + b - 7), word);
      end
      expLen = termPos;
   endtask

   task automatic startPrint(input int line);
      printAddr   = byteAddrT'(line * lineBytes + ($unsigned($random(seed)) % lineBytes));
      printStrobe = 1'b1;
      nextCycle();
      printStrobe = 1'b0;
   endtask

   task automatic waitPrint(input int target);
      while (doneCount < target) @(negedge dvtFlags);
      nextCycle();
   endtask

   task automatic pcStep(input pcT pc);
      logic passHit;
      logic failHit;
      int   cnt;
      cnt     = (pc == lastPcM) ? repeatM + 1 : 0;
      passHit = (pc[pcCmpBits-1:0] == passPc[pcCmpBits-1:0]);
      failHit = (pc[pcCmpBits-1:0] == failPc[pcCmpBits-1:0]) || (cnt >= stuckLimit);
      lastPcM = pc;
      repeatM = cnt;
      curPc   = pc;
      pcValid = 1'b1;
      nextCycle();
      pcValid = 1'b0;
      if (!expPassed && !expFailed) begin   // first decision latches, fail wins
         expFailed = failHit;
         expPassed = passHit && !failHit;
      end
   endtask

   task automatic applyReset();
      expPassed = 1'b0;
      expFailed = 1'b0;
      lastPcM   = '0;
      repeatM   = 0;
      resetReq  = 1'b1;
      nextCycle();
      resetReq  = 1'b0;
      @(negedge pcFail);
      nextCycle();
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      dataT     fillWord;
      byteAddrT addr;
      int       line;
      pcT       stuckPc;
      seed        = 98;
      resetReq    = 1'b0;
      cmdStrobe   = 1'b0;
      cmdWrite    = 1'b0;
      cmdSize     = sizeByte;
      cmdAddr     = '0;
      cmdData     = '0;
      printStrobe = 1'b0;
      printAddr   = '0;
      pcValid     = 1'b0;
      curPc       = '0;
      passPc      = 64'h0000_0040_8000_1000;
      failPc      = 64'h0000_0040_8000_2000;
      expRsp      = '0;
      expLen      = 0;
      expPassed   = 1'b0;
      expFailed   = 1'b0;
      lastPcM     = '0;
      repeatM     = 0;
      for (int b = 0; b < lineBytes; b++) expLine[b] = '0;
      @(negedge pcFail);
      nextCycle();

      // known contents everywhere before any read
      for (int w = 0; w < memWords; w++) begin
         for (int b = 0; b < byteLanes; b++) fillWord[b*8 +: 8] = fillByte(w * byteLanes + b);
         hostCmd(1'b1, sizeDouble, byteAddrT'(w * byteLanes), fillWord);
      end

      // random sized writes, each read back in the same word
      for (int n = 0; n < numPairs; n++) begin
         addr = byteAddrT'($random(seed));
         randomCmd(1'b1, addr);
         randomCmd(1'b0, {addr[10:3], 3'($random(seed))});
      end

      // overlapping writes merged in one word
      addr = {8'($random(seed)), 3'b000};
      hostCmd(1'b1, sizeDouble, addr, rand64());
      hostCmd(1'b1, sizeWord, addr + 4, rand64());
      hostCmd(1'b1, sizeHalf, addr + 2, rand64());
      hostCmd(1'b1, sizeByte, addr + 1, rand64());
      hostCmd(1'b1, sizeByte, addr + 6, rand64());
      hostCmd(1'b0, sizeDouble, addr, '0);

      // terminated lines
      for (int n = 0; n < 2; n++) begin
         line = $unsigned($random(seed)) % lineWords;
         loadLine(line, $unsigned($random(seed)) % lineBytes);
         startPrint(line);
         waitPrint(n + 1);
      end

      // full line under host traffic, writes kept off the printed line
      line = $unsigned($random(seed)) % lineWords;
      loadLine(line, lineBytes);
      startPrint(line);
      for (int n = 0; n < numBusyCmds; n++) begin
         addr = byteAddrT'($random(seed));
         if (addr[10:7] == 4'(line)) addr[10] = ~addr[10];
         randomCmd(n[0], addr);
      end
      waitPrint(3);

      // pass, then a fail hit that must not change it
      for (int n = 0; n < numPcSteps; n++) pcStep(randomPc());
      pcStep(hitPc(passPc));
      pcStep(hitPc(failPc));
      pcStep(randomPc());
      applyReset();
      for (int n = 0; n < numPcSteps; n++) pcStep(randomPc());
      pcStep(hitPc(failPc));
      pcStep(hitPc(passPc));
      pcStep(randomPc());
      applyReset();

      // stuck PC
      stuckPc = randomPc();
      repeat (stuckLimit + 2) pcStep(stuckPc);
      nextCycle();

      $display("errors: %0d, responses: %0d, characters: %0d, prints: %0d",
               errCount, rspCount, charCount, doneCount);
      if (errCount == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   always @(posedge dvtFlags) begin
      cycleCnt = cycleCnt + 1;
      if (cycleCnt > timeoutCycles) begin
         $display("timeout: run still going after %0d cycles", timeoutCycles);
         $display("errors: %0d", errCount);
         $display("Done: errors found");
         $finish;
      end
   end

endmodule

// File: testCtlPkg.sv
// shared widths, types and constants for the test-control block
// imported with a wildcard in each module header

package testCtlPkg;

   // --------------------------------------------------
   // sizes
   // --------------------------------------------------
   localparam int memWords   = 256;
   localparam int lineWords  = 16;   // one 128-byte print line
   localparam int lineBytes  = 128;
   localparam int byteLanes  = 8;    // lanes per memory word
   localparam int laneBits   = 8;
   localparam int pcCmpBits  = 30;   // low PC bits that are compared
   localparam int stuckLimit = 500;

   // print terminators
   localparam logic [7:0] charNul = 8'h00;
   localparam logic [7:0] charLf  = 8'h0A;
   localparam logic [7:0] charCr  = 8'h0D;

   // lane masks
   localparam logic [7:0] wordMaskLo = 8'h0F;
   localparam logic [7:0] wordMaskHi = 8'hF0;
   localparam logic [7:0] fullMask   = 8'hFF;

   // --------------------------------------------------
   // types
   // --------------------------------------------------
   typedef logic [10:0] byteAddrT;
   typedef logic [7:0]  wordAddrT;
   typedef logic [63:0] dataT;
   typedef logic [7:0]  maskT;
   typedef logic [7:0]  charT;
   typedef logic [63:0] pcT;
   typedef logic [$clog2(stuckLimit + 1)-1:0] repeatCntT;

   typedef enum logic [1:0] {
      sizeByte,
      sizeHalf,
      sizeWord,
      sizeDouble
   } accessSizeT;

   typedef enum logic [1:0] {
      scanIdle,
      scanRead,    // issuing reads and draining
      scanDrain    // all reads issued
   } scanStateT;

endpackage

// File: testCtlTop.sv
// top of the test-control block
// host port and print scanner share one memory, plus the PC monitor

`timescale 1ns/1ps

module testCtlTop import testCtlPkg::*; (
   input  logic       dvtFlags,
   input  logic       pcFail,
   // host port
   input  logic       cmdStrobe,
   input  logic       cmdWrite,
   input  accessSizeT cmdSize,
   input  byteAddrT   cmdAddr,
   input  dataT       cmdData,
   output logic       rspValid,
   output dataT       rspData,
   // print port
   input  logic       printStrobe,
   input  byteAddrT   printAddr,
   output logic       charValid,
   output charT       charData,
   output logic       printDone,
   output logic       printBusy,
   // core trace
   input  logic       pcValid,
   input  pcT         curPc,
   input  pcT         passPc,
   input  pcT         failPc,
   output logic       testPassed,
   output logic       testFailed
);

   logic     hostReq, hostWriteEn, hostGrant, hostRdValid;
   wordAddrT hostAddr;
   maskT     hostMask;
   dataT     hostWrData;
   logic     scanReq, scanGrant, scanRdValid;
   wordAddrT scanAddr;
   dataT     rdData;
   logic     memWriteEn;
   wordAddrT memAddr;
   maskT     memMask;
   dataT     memWrData, memRdData;

   hostAccessUnit u_host (
      .dvtFlags, .pcFail, .cmdStrobe, .cmdWrite, .cmdSize, .cmdAddr, .cmdData,
      .rspValid, .rspData,
      .req(hostReq), .writeEn(hostWriteEn), .wordAddr(hostAddr), .mask(hostMask),
      .wrData(hostWrData), .grant(hostGrant), .rdValid(hostRdValid), .rdData(rdData)
   );

   printScanner u_scan (
      .dvtFlags, .pcFail, .printStrobe, .printAddr,
      .charValid, .charData, .printDone, .printBusy,
      .req(scanReq), .wordAddr(scanAddr), .grant(scanGrant),
      .rdValid(scanRdValid), .rdData(rdData)
   );

   memArbiter u_arb (
      .dvtFlags, .pcFail,
      .hostReq, .hostWriteEn, .hostAddr, .hostMask, .hostWrData, .hostGrant,
      .scanReq, .scanAddr, .scanGrant,
      .memWriteEn, .memAddr, .memMask, .memWrData, .memRdData,
      .rdData, .hostRdValid, .scanRdValid
   );

   sharedMem u_mem (
      .dvtFlags, .pcFail, .writeEn(memWriteEn), .wordAddr(memAddr),
      .mask(memMask), .wrData(memWrData), .rdData(memRdData)
   );

   pcMonitor u_pcMon (
      .dvtFlags, .pcFail, .pcValid, .curPc, .passPc, .failPc, .testPassed, .testFailed
   );

endmodule

// File: testCtl_assert.sv
// protocol assertions on the test-control top level
// bound into every testCtlTop instance

`timescale 1ns/1ps

module testCtlAssert (
   input logic dvtFlags,
   input logic pcFail,
   input logic cmdStrobe,
   input logic rspValid,
   input logic charValid,
   input logic printBusy,
   input logic testPassed,
   input logic testFailed
);

   // host always wins, so the response time is fixed
   rspTiming: assert property (@(posedge dvtFlags) disable iff (pcFail)
      cmdStrobe |-> ##2 rspValid)
      else $error("rspValid did not follow cmdStrobe after 2 cycles");

   charWhileIdle: assert property (@(posedge dvtFlags) disable iff (pcFail)
      !(charValid && !printBusy))
      else $error("charValid high while the scanner is idle");

   statusExclusive: assert property (@(posedge dvtFlags) disable iff (pcFail)
      !(testPassed && testFailed))
      else $error("testPassed and testFailed both high");

   passSticky: assert property (@(posedge dvtFlags) disable iff (pcFail)
      testPassed |=> testPassed)
      else $error("testPassed dropped without reset");

   failSticky: assert property (@(posedge dvtFlags) disable iff (pcFail)
      testFailed |=> testFailed)
      else $error("testFailed dropped without reset");

endmodule

bind testCtlTop testCtlAssert u_assert (.*);
